/* verilog/chanalign_pkg.sv */
package chanalign_pkg;

  typedef logic [7:0]  drp_addr_t;
  typedef logic [15:0] drp_data_t;
  typedef logic [5:0]  ltssm_t;

  typedef enum logic {
    mode_ts1,
    mode_fts
  } align_mode_t;

  typedef enum logic [2:0] {
    st_reset,
    st_write_ts1,
    st_wait_ts1,
    st_idle_ts1,
    st_write_fts,
    st_wait_fts,
    st_idle_fts
  } drp_state_t;

  localparam drp_addr_t align_first_addr = 8'h08;
  localparam drp_addr_t align_last_addr  = 8'h0B;

  // comma-detect words for addresses 8 to 11, in address order.
  localparam drp_data_t ts1_pattern [4] = '{16'hFC4A, 16'hDC4A, 16'hC04A, 16'h85BC};
  localparam drp_data_t fts_pattern [4] = '{16'hFD3C, 16'hC53C, 16'hFDBC, 16'h853C};

  localparam ltssm_t ltssm_polling_lo  = 6'h02;
  localparam ltssm_t ltssm_polling_hi  = 6'h0A;
  localparam ltssm_t ltssm_config_lo   = 6'h0B;
  localparam ltssm_t ltssm_config_hi   = 6'h15;
  localparam ltssm_t ltssm_l0          = 6'h16;
  localparam ltssm_t ltssm_recovery_lo = 6'h20;
  localparam ltssm_t ltssm_recovery_hi = 6'h2B;

endpackage

/* verilog/align_mode_detect.sv */
module align_mode_detect (
  input  logic                       drp_clk,
  input  logic                       reset,
  input  chanalign_pkg::ltssm_t      ltssm_state,
  output chanalign_pkg::align_mode_t align_mode
);

  import chanalign_pkg::*;

  logic in_polling;
  logic in_config;
  logic in_recovery;
  logic in_training;
  logic in_l0;

  function automatic logic code_in_range(ltssm_t code, ltssm_t lo, ltssm_t hi);
    return (code >= lo) && (code <= hi);
  endfunction

  always_comb begin
    in_polling  = code_in_range(ltssm_state, ltssm_polling_lo, ltssm_polling_hi);
    in_config   = code_in_range(ltssm_state, ltssm_config_lo, ltssm_config_hi);
    in_recovery = code_in_range(ltssm_state, ltssm_recovery_lo, ltssm_recovery_hi);
    in_training = in_polling || in_config || in_recovery;
    in_l0       = (ltssm_state == ltssm_l0);
  end

  // other codes keep the last mode, so short detours do not trigger a rewrite.
  always_ff @(posedge drp_clk) begin
    if (reset) begin
      align_mode <= mode_ts1;
    end else if (in_l0) begin
      align_mode <= mode_fts;
    end else if (in_training) begin
      align_mode <= mode_ts1;
    end
  end

endmodule

/* verilog/drp_chanalign_sequencer.sv */
module drp_chanalign_sequencer (
  input  logic                       drp_clk,
  input  logic                       reset,
  input  chanalign_pkg::align_mode_t align_mode,
  input  logic                       seq_drdy,
  output logic                       seq_den,
  output logic                       seq_dwe,
  output chanalign_pkg::drp_addr_t   seq_daddr,
  output chanalign_pkg::drp_data_t   seq_di,
  output chanalign_pkg::drp_state_t  drp_state,
  output logic                       seq_busy
);

  import chanalign_pkg::*;

  drp_state_t state;
  drp_state_t next_state;
  drp_addr_t  addr_cnt;
  drp_addr_t  next_addr;
  logic [1:0] pattern_idx;
  logic       last_addr;

  assign pattern_idx = 2'(addr_cnt - align_first_addr);
  assign last_addr   = (addr_cnt == align_last_addr);

  always_ff @(posedge drp_clk) begin
    if (reset) begin
      state    <= st_reset;
      addr_cnt <= align_first_addr;
    end else begin
      state    <= next_state;
      addr_cnt <= next_addr;
    end
  end

  always_comb begin
    next_state = state;
    next_addr  = addr_cnt;
    seq_den    = 1'b0;
    seq_dwe    = 1'b0;
    seq_di     = '0;
    case (state)
      st_reset: begin
        next_state = st_write_ts1;
        next_addr  = align_first_addr;
      end
      st_write_ts1: begin
        seq_den    = 1'b1; // a write state lasts one cycle, so den is a pulse.
        seq_dwe    = 1'b1;
        seq_di     = ts1_pattern[pattern_idx];
        next_state = st_wait_ts1;
      end
      st_wait_ts1: begin
        if (seq_drdy) begin
          if (last_addr) begin
            next_state = st_idle_ts1;
            next_addr  = align_first_addr;
          end else begin
            next_state = st_write_ts1;
            next_addr  = addr_cnt + 8'd1;
          end
        end
      end
      st_idle_ts1: begin
        if (align_mode == mode_fts) begin
          next_state = st_write_fts;
          next_addr  = align_first_addr;
        end
      end
      st_write_fts: begin
        seq_den    = 1'b1;
        seq_dwe    = 1'b1;
        seq_di     = fts_pattern[pattern_idx];
        next_state = st_wait_fts;
      end
      st_wait_fts: begin
        if (seq_drdy) begin
          if (last_addr) begin
            next_state = st_idle_fts;
            next_addr  = align_first_addr;
          end else begin
            next_state = st_write_fts;
            next_addr  = addr_cnt + 8'd1;
          end
        end
      end
      st_idle_fts: begin
        if (align_mode == mode_ts1) begin
          next_state = st_write_ts1;
          next_addr  = align_first_addr;
        end
      end
      default: begin
        next_state = st_reset;
      end
    endcase
  end

  assign seq_daddr = addr_cnt;
  assign drp_state = state;
  // a mode change seen mid-sequence is picked up here once the idle state is reached.
  assign seq_busy  = (state != st_idle_ts1) && (state != st_idle_fts);

endmodule

/* verilog/drp_port_arbiter.sv */
module drp_port_arbiter (
  input  logic                     drp_clk,
  input  logic                     reset,
  input  logic                     seq_den,
  input  logic                     seq_dwe,
  input  chanalign_pkg::drp_addr_t seq_daddr,
  input  chanalign_pkg::drp_data_t seq_di,
  output logic                     seq_drdy,
  input  logic                     user_den,
  input  logic                     user_dwe,
  input  chanalign_pkg::drp_addr_t user_daddr,
  input  chanalign_pkg::drp_data_t user_di,
  output chanalign_pkg::drp_data_t user_do,
  output logic                     user_drdy,
  output logic                     den,
  output logic                     dwe,
  output chanalign_pkg::drp_addr_t daddr,
  output chanalign_pkg::drp_data_t di,
  input  chanalign_pkg::drp_data_t dout,
  input  logic                     drdy
);

  import chanalign_pkg::*;

  logic      seq_pend;
  logic      seq_pend_dwe;
  drp_addr_t seq_pend_addr;
  drp_data_t seq_pend_data;
  logic      user_pend;
  logic      user_pend_dwe;
  drp_addr_t user_pend_addr;
  drp_data_t user_pend_data;
  logic      busy;
  logic      owner_user;
  logic      seq_req;
  logic      user_req;
  logic      issue;
  logic      grant_seq;
  logic      grant_user;

  assign seq_req    = seq_den || seq_pend;
  assign user_req   = user_den || user_pend;
  assign issue      = !busy && (seq_req || user_req);
  assign grant_seq  = issue && seq_req; // the sequencer has priority.
  assign grant_user = issue && !seq_req;

  // a live den is forwarded directly, otherwise the buffered copy is used.
  always_comb begin
    den   = issue;
    dwe   = 1'b0;
    daddr = '0;
    di    = '0;
    if (grant_seq) begin
      dwe   = seq_den ? seq_dwe : seq_pend_dwe;
      daddr = seq_den ? seq_daddr : seq_pend_addr;
      di    = seq_den ? seq_di : seq_pend_data;
    end else if (grant_user) begin
      dwe   = user_den ? user_dwe : user_pend_dwe;
      daddr = user_den ? user_daddr : user_pend_addr;
      di    = user_den ? user_di : user_pend_data;
    end
  end

  always_ff @(posedge drp_clk) begin
    if (reset) begin
      seq_pend   <= 1'b0;
      user_pend  <= 1'b0;
      busy       <= 1'b0;
      owner_user <= 1'b0;
    end else begin
      seq_pend  <= seq_req && !grant_seq;
      user_pend <= user_req && !grant_user;
      if (issue) begin
        busy       <= 1'b1;
        owner_user <= grant_user;
      end else if (drdy) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge drp_clk) begin
    if (seq_den) begin
      seq_pend_dwe  <= seq_dwe;
      seq_pend_addr <= seq_daddr;
      seq_pend_data <= seq_di;
    end
    if (user_den) begin
      user_pend_dwe  <= user_dwe;
      user_pend_addr <= user_daddr;
      user_pend_data <= user_di;
    end
  end

  assign seq_drdy  = drdy && busy && !owner_user;
  assign user_drdy = drdy && busy && owner_user;
  assign user_do   = dout;

endmodule

/* verilog/gtx_chanalign_fix.sv */
module gtx_chanalign_fix (
  input  logic                      drp_clk,
  input  logic                      reset,
  input  chanalign_pkg::ltssm_t     ltssm_state,
  input  logic                      user_den,
  input  logic                      user_dwe,
  input  chanalign_pkg::drp_addr_t  user_daddr,
  input  chanalign_pkg::drp_data_t  user_di,
  output chanalign_pkg::drp_data_t  user_do,
  output logic                      user_drdy,
  output logic                      den,
  output logic                      dwe,
  output chanalign_pkg::drp_addr_t  daddr,
  output chanalign_pkg::drp_data_t  di,
  input  chanalign_pkg::drp_data_t  dout,
  input  logic                      drdy,
  output chanalign_pkg::drp_state_t drp_state,
  output logic                      seq_busy
);

  import chanalign_pkg::*;

  align_mode_t align_mode;
  logic        seq_den;
  logic        seq_dwe;
  drp_addr_t   seq_daddr;
  drp_data_t   seq_di;
  logic        seq_drdy;

  align_mode_detect u_detect (
    .drp_clk     (drp_clk),
    .reset       (reset),
    .ltssm_state (ltssm_state),
    .align_mode  (align_mode)
  );

  drp_chanalign_sequencer u_sequencer (
    .drp_clk    (drp_clk),
    .reset      (reset),
    .align_mode (align_mode),
    .seq_drdy   (seq_drdy),
    .seq_den    (seq_den),
    .seq_dwe    (seq_dwe),
    .seq_daddr  (seq_daddr),
    .seq_di     (seq_di),
    .drp_state  (drp_state),
    .seq_busy   (seq_busy)
  );

  drp_port_arbiter u_arbiter (
    .drp_clk    (drp_clk),
    .reset      (reset),
    .seq_den    (seq_den),
    .seq_dwe    (seq_dwe),
    .seq_daddr  (seq_daddr),
    .seq_di     (seq_di),
    .seq_drdy   (seq_drdy),
    .user_den   (user_den),
    .user_dwe   (user_dwe),
    .user_daddr (user_daddr),
    .user_di    (user_di),
    .user_do    (user_do),
    .user_drdy  (user_drdy),
    .den        (den),
    .dwe        (dwe),
    .daddr      (daddr),
    .di         (di),
    .dout       (dout),
    .drdy       (drdy)
  );

endmodule

/* verification/drp_target_model.sv */
module drp_target_model (
  input  logic                     drp_clk,
  input  logic                     reset,
  input  logic                     den,
  input  logic                     dwe,
  input  chanalign_pkg::drp_addr_t daddr,
  input  chanalign_pkg::drp_data_t di,
  output chanalign_pkg::drp_data_t dout,
  output logic                     drdy
);

  timeunit 1ns;
  timeprecision 100ps;

  import chanalign_pkg::*;

  integer      seed = 32'hb7b4;
  drp_data_t   mem [256];
  logic        den_q = 1'b0;
  logic        dwe_q = 1'b0;
  drp_addr_t   addr_q = '0;
  drp_data_t   data_q = '0;
  logic        pending = 1'b0;
  logic        req_dwe = 1'b0;
  drp_addr_t   req_addr = '0;
  drp_data_t   req_data = '0;
  int unsigned wait_cnt = 0;
  logic        drdy_r = 1'b0;
  drp_data_t   dout_r = '0;

  assign drdy = drdy_r;
  assign dout = dout_r;

  always @(posedge drp_clk) begin
    den_q  <= den; // the request is sampled on the rising edge.
    dwe_q  <= dwe;
    addr_q <= daddr;
    data_q <= di;
  end

  // responses change on the falling edge, 1 to 4 cycles after the request.
  always @(negedge drp_clk) begin
    drdy_r <= 1'b0;
    if (reset) begin
      pending = 1'b0;
      for (int i = 0; i < 256; i++) begin
        mem[i] = {i[7:0], ~i[7:0]}; // every word differs with its address.
      end
    end else begin
      if (den_q) begin
        req_dwe  = dwe_q;
        req_addr = addr_q;
        req_data = data_q;
        pending  = 1'b1;
        wait_cnt = 1 + ($unsigned($random(seed)) % 4);
      end
      if (pending) begin
        if (wait_cnt > 1) begin
          wait_cnt = wait_cnt - 1;
        end else begin
          if (req_dwe) begin
            mem[req_addr] = req_data;
          end else begin
            dout_r <= mem[req_addr];
          end
          drdy_r  <= 1'b1;
          pending = 1'b0;
        end
      end
    end
  end

endmodule

/* verification/tb_gtx_chanalign_fix.sv */
module tb_gtx_chanalign_fix;

  timeunit 1ns;
  timeprecision 100ps;

  import chanalign_pkg::*;

  localparam int clk_period   = 8;
  localparam int num_tests    = 5;
  localparam int cycle_budget = 2000;

  // comma-detect words expected at addresses 8 to 11.
  localparam drp_data_t exp_ts1 [4] = '{16'hFC4A, 16'hDC4A, 16'hC04A, 16'h85BC};
  localparam drp_data_t exp_fts [4] = '{16'hFD3C, 16'hC53C, 16'hFDBC, 16'h853C};

  logic       drp_clk;
  logic       reset;
  ltssm_t     ltssm_state;
  logic       user_den;
  logic       user_dwe;
  drp_addr_t  user_daddr;
  drp_data_t  user_di;
  drp_data_t  user_do;
  logic       user_drdy;
  logic       den;
  logic       dwe;
  drp_addr_t  daddr;
  drp_data_t  di;
  drp_data_t  dout;
  logic       drdy;
  drp_state_t drp_state;
  logic       seq_busy;

  gtx_chanalign_fix dut0 (.*);

  drp_target_model target0 (
    .drp_clk (drp_clk),
    .reset   (reset),
    .den     (den),
    .dwe     (dwe),
    .daddr   (daddr),
    .di      (di),
    .dout    (dout),
    .drdy    (drdy)
  );

  initial begin
    drp_clk = 1'b0;
    forever #(clk_period / 2) drp_clk = ~drp_clk;
  end

  initial begin
    #(num_tests * cycle_budget * clk_period);
    $display("Watchdog expired: the tests did not finish within their cycle budget.");
    stop_on_error();
  end

  task automatic stop_on_error();
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(input drp_data_t act, input drp_data_t exp, input string what);
    if (act !== exp) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, act, exp);
      stop_on_error();
    end
  endtask

  task automatic check_state(input drp_state_t act, input drp_state_t exp, input string what);
    if (act !== exp) begin
      $display("Mismatch at %0t ns: %s is %s, expected %s", $time, what, act.name(), exp.name());
      stop_on_error();
    end
  endtask

  task automatic set_ltssm(input ltssm_t code);
    @(negedge drp_clk);
    ltssm_state = code;
  endtask

  // samples 2 ns after the falling edge, where drdy and the owner flag are both settled.
  task automatic wait_user_drdy();
    int cycles = 0;
    #2;
    while (user_drdy !== 1'b1) begin
      if (cycles == 50) begin
        $display("User DRP access got no drdy within 50 cycles.");
        stop_on_error();
      end
      cycles++;
      @(negedge drp_clk);
      #2;
    end
  endtask

  task automatic user_write(input drp_addr_t addr, input drp_data_t data);
    @(negedge drp_clk);
    user_den   = 1'b1;
    user_dwe   = 1'b1;
    user_daddr = addr;
    user_di    = data;
    @(negedge drp_clk);
    user_den = 1'b0;
    user_dwe = 1'b0;
    wait_user_drdy();
  endtask

  task automatic user_read(input drp_addr_t addr, output drp_data_t data);
    @(negedge drp_clk);
    user_den   = 1'b1;
    user_dwe   = 1'b0;
    user_daddr = addr;
    @(negedge drp_clk);
    user_den = 1'b0;
    wait_user_drdy();
    data = user_do; // do is valid in the drdy cycle.
  endtask

  task automatic wait_idle();
    int cycles = 0;
    @(negedge drp_clk);
    while (seq_busy) begin
      if (cycles == 400) begin
        $display("Sequencer stayed busy for 400 cycles.");
        stop_on_error();
      end
      cycles++;
      @(negedge drp_clk);
    end
  endtask

  task automatic wait_busy();
    int cycles = 0;
    @(negedge drp_clk);
    while (!seq_busy) begin
      if (cycles == 4) begin
        $display("Sequencer did not start a sequence after the mode change.");
        stop_on_error();
      end
      cycles++;
      @(negedge drp_clk);
    end
  endtask

  task automatic check_pattern_regs(input drp_data_t exp [4], input string what);
    drp_data_t word;
    for (int i = 0; i < 4; i++) begin
      user_read(drp_addr_t'(8 + i), word);
      check_data(word, exp[i], $sformatf("%s at address %0d", what, 8 + i));
    end
  endtask

  task automatic check_other_code_holds(input drp_state_t exp_state, input drp_data_t exp [4],
                                        input string what);
    set_ltssm(6'h00); // outside polling, configuration, recovery and L0.
    repeat (10) begin
      @(negedge drp_clk);
      if (seq_busy) begin
        $display("Sequencer started on a code outside all training groups.");
        stop_on_error();
      end
    end
    check_state(drp_state, exp_state, $sformatf("state after an other code in %s", what));
    check_pattern_regs(exp, $sformatf("%s word after an other code", what));
  endtask

  task automatic test_reset_state();
    wait_idle();
    check_state(drp_state, st_idle_ts1, "state after reset");
    check_pattern_regs(exp_ts1, "TS1 word after reset");
  endtask

  task automatic test_enter_l0();
    set_ltssm(ltssm_l0);
    wait_busy();
    wait_idle();
    check_state(drp_state, st_idle_fts, "state in L0");
    check_pattern_regs(exp_fts, "FTS word in L0");
  endtask

  task automatic test_recovery_and_other();
    check_other_code_holds(st_idle_fts, exp_fts, "FTS");
    set_ltssm(ltssm_recovery_hi);
    wait_busy();
    wait_idle();
    check_state(drp_state, st_idle_ts1, "state in recovery");
    check_pattern_regs(exp_ts1, "TS1 word in recovery");
    check_other_code_holds(st_idle_ts1, exp_ts1, "TS1");
  endtask

  task automatic test_user_access_during_sequence();
    drp_data_t word;
    set_ltssm(ltssm_l0);
    wait_busy();
    user_write(8'h30, 16'hA5C3);
    user_read(8'h30, word);
    check_data(word, 16'hA5C3, "user read-back at address 0x30");
    wait_idle();
    check_state(drp_state, st_idle_fts, "state after shared access");
    check_pattern_regs(exp_fts, "FTS word after shared access");
  endtask

  task automatic test_mode_change_mid_sequence();
    repeat (3) begin
      set_ltssm(ltssm_config_lo);
      wait_busy();
      repeat (2) @(negedge drp_clk);
      set_ltssm(ltssm_l0);
      wait_idle();
      check_state(drp_state, st_idle_ts1, "state after the interrupted sequence");
      wait_busy();
      wait_idle();
      check_state(drp_state, st_idle_fts, "state after the second sequence");
      check_pattern_regs(exp_fts, "FTS word after a mid-sequence change");
    end
  endtask

  initial begin
    reset       = 1'b1;
    ltssm_state = ltssm_polling_lo;
    user_den    = 1'b0;
    user_dwe    = 1'b0;
    user_daddr  = '0;
    user_di     = '0;
    repeat (3) @(posedge drp_clk);
    @(negedge drp_clk);
    reset = 1'b0;
    test_reset_state();
    test_enter_l0();
    test_recovery_and_other();
    test_user_access_during_sequence();
    test_mode_change_mid_sequence();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* flist.f */
verilog/chanalign_pkg.sv
verilog/align_mode_detect.sv
verilog/drp_chanalign_sequencer.sv
verilog/drp_port_arbiter.sv
verilog/gtx_chanalign_fix.sv
verification/drp_target_model.sv
verification/tb_gtx_chanalign_fix.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; a $fatal gives a failing exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f flist.f \
  --top-module tb_gtx_chanalign_fix \
  -o sim_tb

./obj_dir/sim_tb
